/* list.f */
+incdir+include
logic/tunnel_pkg.sv
logic/two_fifo.sv
logic/hop_pipe.sv
logic/tunnel_mux.sv
logic/tunnel_demux.sv
logic/tunnel_top.sv
bench/tunnel_props.sv
bench/tunnel_tb.sv

/* Bender.yml */
package:
  name: tunnel

sources:
  - include_dirs:
      - include
    files:
      - logic/tunnel_pkg.sv
      - logic/two_fifo.sv
      - logic/hop_pipe.sv
      - logic/tunnel_mux.sv
      - logic/tunnel_demux.sv
      - logic/tunnel_top.sv

  - target: simulation
    include_dirs:
      - include
    files:
      - bench/tunnel_props.sv
      - bench/tunnel_tb.sv

/* bench/tunnel_tests.txt */
# Columns: command test_name channel_or_count value_hex
# send queues a word, rand queues count random words, stall value 1 holds ch_ready_i low
idle   after_reset
send   ch0_order 0 1001
send   ch0_order 0 1002
send   ch1_order 1 2001
send   ch1_order 1 2002
send   ch2_order 2 3001
send   ch2_order 2 3002
drain  order
rand   mixed_a 30
drain  mixed_a
rand   mixed_b 30
drain  mixed_b
stall  bp_ch1 1 1
send   bp_ch1 1 a001
send   bp_ch1 1 a002
send   bp_ch1 1 a003
send   bp_ch1 1 a004
send   bp_ch1 1 a005
send   bp_ch1 1 a006
send   bp_ch1 1 a007
send   bp_ch1 1 a008
block  bp_ch1 1
send   bp_others 0 b001
send   bp_others 2 c001
send   bp_others 0 b002
send   bp_others 2 c002
drain  bp_others
stall  release_ch1 1 0
drain  release_ch1
send   after_release 1 d001
send   after_release 1 d002
send   after_release 1 d003
send   after_release 1 d004
send   after_release 1 d005
send   after_release 1 d006
drain  after_release
idle   final_idle

/* bench/tunnel_tb.sv */
`timescale 1ns/1ns

`include "tunnel_defs.svh"

module tunnel_tb
  import tunnel_pkg::*;
();

  localparam int NUM_CHAN  = `TUNNEL_NUM_CHAN;
  localparam int ACC_LIMIT = `TUNNEL_CREDITS + 2;  // Remote buffer plus input buffer

  logic                    core_clk_i = 1'b0;
  logic                    arst_n_i;
  logic     [NUM_CHAN-1:0] ch_v_i;
  payload_t [NUM_CHAN-1:0] ch_data_i;
  logic     [NUM_CHAN-1:0] ch_ready_o;
  logic     [NUM_CHAN-1:0] ch_v_o;
  payload_t [NUM_CHAN-1:0] ch_data_o;
  logic     [NUM_CHAN-1:0] ch_ready_i;
  logic                    link_v;
  link_word_t              link_data;
  logic                    link_ready;

  string       cmd_q [$];
  string       name_q [$];
  int          arg_q [$];
  logic [31:0] val_q [$];

  payload_t tx_q       [NUM_CHAN][$];
  string    tx_name_q  [NUM_CHAN][$];
  payload_t exp_q      [NUM_CHAN][$];  // Accepted, not yet delivered
  string    exp_name_q [NUM_CHAN][$];

  logic [NUM_CHAN-1:0] acc_now = '0;
  logic [NUM_CHAN-1:0] stall   = '0;
  int                  acc_cnt [NUM_CHAN];
  int                  gap_cnt [NUM_CHAN];
  int                  link_ahead [NUM_CHAN];  // Seen on the link, not yet delivered
  logic [31:0]         lcg_state   = 32'hbcb6_2bc0;
  int                  cycle_cnt   = 0;
  int                  cycle_limit = 1000;

  always #4 core_clk_i = ~core_clk_i;

  // Link pins looped back so each channel talks to itself
  tunnel_top tunnel_top_inst
  (
    .core_clk_i, .arst_n_i,
    .ch_v_i, .ch_data_i, .ch_ready_o,
    .ch_v_o, .ch_data_o, .ch_ready_i,
    .link_v_o(link_v), .link_data_o(link_data), .link_ready_i(link_ready),
    .link_v_i(link_v), .link_data_i(link_data), .link_ready_o(link_ready)
  );

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic report_fail(input string msg);
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1, "Run stopped at first error");
  endtask

  task automatic check_payload(input string name, input payload_t exp, input payload_t act);
    if (exp !== act)
      report_fail($sformatf("CHECK FAILED %s: expected payload %h, actual %h", name, exp, act));
  endtask

  task automatic check_chan(input string name, input chan_id_t exp, input chan_id_t act);
    if (exp !== act)
      report_fail($sformatf("CHECK FAILED %s: expected channel %0d, actual %0d", name, exp, act));
  endtask

  task automatic check_flags(input string name, input logic [NUM_CHAN-1:0] exp,
                             input logic [NUM_CHAN-1:0] act);
    if (exp !== act)
      report_fail($sformatf("CHECK FAILED %s: expected flags %b, actual %b", name, exp, act));
  endtask

  task automatic check_level(input string name, input logic exp, input logic act);
    if (exp !== act)
      report_fail($sformatf("CHECK FAILED %s: expected link level %b, actual %b",
                            name, exp, act));
  endtask

  task automatic load_tests();
    int          fd;
    int          n;
    string       line;
    string       cmd;
    string       name;
    int          arg;
    logic [31:0] val;
    fd = $fopen("bench/tunnel_tests.txt", "r");
    if (fd == 0)
      report_fail("Could not open the test file bench/tunnel_tests.txt");
    while (!$feof(fd))
    begin
      line = "";
      cmd  = "";
      arg  = 0;
      val  = '0;
      void'($fgets(line, fd));
      n = $sscanf(line, "%s %s %d %h", cmd, name, arg, val);
      if (n >= 2 && cmd.substr(0, 0) != "#")
      begin
        cmd_q.push_back(cmd);
        name_q.push_back(name);
        arg_q.push_back(arg);
        val_q.push_back(val);
      end
    end
    $fclose(fd);
  endtask

  // Away from both clock edges, so the DUT and the driver have settled
  task automatic step();
    @(negedge core_clk_i);
    #1;
  endtask

  task automatic drain_idle();
    logic busy;
    busy = 1'b1;
    while (busy)
    begin
      step();
      busy = 1'b0;
      for (int k = 0; k < NUM_CHAN; k++)
        if (!stall[k] && (tx_q[k].size() != 0 || exp_q[k].size() != 0))
          busy = 1'b1;
    end
  endtask

  task automatic wait_blocked(input string name, input int ch);
    while (ch_ready_o[ch])
      step();
    repeat (20)
      step();
    if (ch_ready_o[ch])
      report_fail($sformatf("%s: stalled channel %0d became ready again", name, ch));
    if (acc_cnt[ch] > ACC_LIMIT)
      report_fail($sformatf("CHECK FAILED %s: expected at most %0d words, actual %0d",
                            name, ACC_LIMIT, acc_cnt[ch]));
  endtask

  // Driver, a nanosecond after the rising edge
  always @(posedge core_clk_i)
  begin
    #1;
    for (int k = 0; k < NUM_CHAN; k++)
    begin
      if (acc_now[k])
      begin
        exp_q[k].push_back(tx_q[k].pop_front());
        exp_name_q[k].push_back(tx_name_q[k].pop_front());
        acc_cnt[k]++;
        gap_cnt[k] = int'(next_random() % 3);
      end
      if (gap_cnt[k] != 0)
      begin
        gap_cnt[k]--;
        ch_v_i[k] = 1'b0;
      end
      else if (tx_q[k].size() != 0)
      begin
        ch_v_i[k]    = 1'b1;
        ch_data_i[k] = tx_q[k][0];
      end
      else
        ch_v_i[k] = 1'b0;
      ch_ready_i[k] = ~stall[k];
    end
  end

  // Scoreboard, on the falling edge where every handshake signal is stable
  always @(negedge core_clk_i)
  begin
    int       src;
    int       lc;
    int       idx;
    payload_t got;
    string    name;
    if (tunnel_top_inst.mux_inst.props_inst.fail_cnt != 0)
      report_fail("An assertion on the tunnel multiplexer failed");
    // Words on the looped link carry their channel tag and come in accepted order
    if (arst_n_i && link_v && link_ready)
    begin
      lc = int'(link_data.chan);
      if (link_data.kind == KIND_CREDIT)
      begin
        if (lc >= NUM_CHAN || link_data.payload == '0 ||
            link_data.payload > `TUNNEL_CREDITS)
          report_fail($sformatf("Credit word for channel %0d carries count %0d",
                                lc, link_data.payload));
      end
      else if (lc >= NUM_CHAN)
        report_fail($sformatf("Data word on the link names unknown channel %0d", lc));
      else if (link_ahead[lc] >= exp_q[lc].size())
        report_fail($sformatf("Link carried a data word on channel %0d that was never sent",
                              lc));
      else
      begin
        idx = link_ahead[lc];
        check_payload(exp_name_q[lc][idx], exp_q[lc][idx], link_data.payload);
        link_ahead[lc]++;
      end
    end
    for (int k = 0; k < NUM_CHAN; k++)
    begin
      acc_now[k] = arst_n_i & ch_v_i[k] & ch_ready_o[k];
      if (arst_n_i && ch_v_o[k] && ch_ready_i[k])
      begin
        got = ch_data_o[k];
        src = k;
        if (exp_q[k].size() == 0 || exp_q[k][0] !== got)
          for (int j = 0; j < NUM_CHAN; j++)
            if (exp_q[j].size() != 0 && exp_q[j][0] === got)
              src = j;  // Word that belongs to another channel
        if (exp_q[src].size() == 0)
          report_fail($sformatf("Channel %0d delivered %h with no word outstanding", k, got));
        else
        begin
          name = exp_name_q[src][0];
          check_chan(name, chan_id_t'(src), chan_id_t'(k));
          check_payload(name, exp_q[src][0], got);
          void'(exp_q[src].pop_front());
          void'(exp_name_q[src].pop_front());
          link_ahead[src]--;
        end
      end
    end
  end

  always @(posedge core_clk_i)
  begin
    cycle_cnt++;
    if (cycle_cnt > cycle_limit)
      report_fail($sformatf("Timeout: the tests did not finish within %0d cycles", cycle_limit));
  end

  initial
  begin
    chan_id_t ch;
    arst_n_i   = 1'b0;
    ch_v_i     = '0;
    ch_data_i  = '0;
    ch_ready_i = '1;
    for (int k = 0; k < NUM_CHAN; k++)
    begin
      acc_cnt[k]    = 0;
      gap_cnt[k]    = 0;
      link_ahead[k] = 0;
    end
    load_tests();
    cycle_limit = 50 * cmd_q.size() + 200;
    repeat (3) @(posedge core_clk_i);
    #1 arst_n_i = 1'b1;

    for (int i = 0; i < cmd_q.size(); i++)
    begin
      step();
      case (cmd_q[i])
        "idle":
        begin
          check_flags(name_q[i], '0, ch_v_o);
          check_flags(name_q[i], '1, ch_ready_o);
          check_level(name_q[i], 1'b1, link_ready);
        end
        "send":
        begin
          tx_q[arg_q[i]].push_back(payload_t'(val_q[i]));
          tx_name_q[arg_q[i]].push_back(name_q[i]);
        end
        "rand":
          for (int n = 0; n < arg_q[i]; n++)
          begin
            ch = chan_id_t'(next_random() % NUM_CHAN);
            tx_q[ch].push_back(payload_t'(next_random() >> 16));
            tx_name_q[ch].push_back(name_q[i]);
          end
        "stall":
        begin
          stall[arg_q[i]]   = val_q[i][0];
          acc_cnt[arg_q[i]] = 0;
        end
        "block":
          wait_blocked(name_q[i], arg_q[i]);
        "drain":
          drain_idle();
        default:
          report_fail($sformatf("Unknown command %s in the test file", cmd_q[i]));
      endcase
    end

    if (tunnel_top_inst.mux_inst.props_inst.fail_cnt != 0)
      report_fail("An assertion on the tunnel multiplexer failed");
    else
    begin
      $display("Testbench passed");
      $finish;
    end
  end

endmodule

/* bench/tunnel_props.sv */
`timescale 1ns/1ns

`include "tunnel_defs.svh"

module tunnel_props
  import tunnel_pkg::*;
#(
  parameter int NUM_CHAN = `TUNNEL_NUM_CHAN
)
(
  input  logic                core_clk_i,
  input  logic                arst_n_i,
  input  credit_cnt_t         cred_i [NUM_CHAN],
  input  logic [NUM_CHAN-1:0] yumi_i,
  input  logic                link_v_i,
  input  link_word_t          link_data_i,
  input  logic                link_ready_i
);

  int fail_cnt = 0;  // Polled by the testbench

  for (genvar k = 0; k < NUM_CHAN; k++)
  begin : chan
    cred_max_a : assert property (@(posedge core_clk_i) disable iff (!arst_n_i)
      cred_i[k] <= credit_cnt_t'(`TUNNEL_CREDITS))
    else
    begin
      $error("Credit counter of channel %0d above its limit", k);
      fail_cnt++;
    end

    // A word taken from the input buffer needs a remote slot
    send_cred_a : assert property (@(posedge core_clk_i) disable iff (!arst_n_i)
      yumi_i[k] |-> cred_i[k] != '0)
    else
    begin
      $error("Data word sent on channel %0d without credit", k);
      fail_cnt++;
    end
  end

  hold_a : assert property (@(posedge core_clk_i) disable iff (!arst_n_i)
    link_v_i && !link_ready_i |=> link_v_i && $stable(link_data_i))
  else
  begin
    $error("Link word changed while stalled");
    fail_cnt++;
  end

endmodule

bind tunnel_mux tunnel_props #(.NUM_CHAN(NUM_CHAN)) props_inst
(
  .core_clk_i   (core_clk_i),
  .arst_n_i     (arst_n_i),
  .cred_i       (remote_cred),
  .yumi_i       (in_yumi_o),
  .link_v_i     (link_v_o),
  .link_data_i  (link_data_o),
  .link_ready_i (link_ready_i)
);

/* logic/tunnel_top.sv */
`timescale 1ns/1ns

`include "tunnel_defs.svh"

module tunnel_top
  import tunnel_pkg::*;
#(
  parameter int NUM_CHAN = `TUNNEL_NUM_CHAN
)
(
  input  logic                    core_clk_i,
  input  logic                    arst_n_i,

  input  logic     [NUM_CHAN-1:0] ch_v_i,
  input  payload_t [NUM_CHAN-1:0] ch_data_i,
  output logic     [NUM_CHAN-1:0] ch_ready_o,

  output logic     [NUM_CHAN-1:0] ch_v_o,
  output payload_t [NUM_CHAN-1:0] ch_data_o,
  input  logic     [NUM_CHAN-1:0] ch_ready_i,

  output logic                    link_v_o,
  output link_word_t              link_data_o,
  input  logic                    link_ready_i,

  input  logic                    link_v_i,
  input  link_word_t              link_data_i,
  output logic                    link_ready_o
);

  logic     [NUM_CHAN-1:0] buf_v;
  payload_t [NUM_CHAN-1:0] buf_data;
  logic     [NUM_CHAN-1:0] buf_yumi;

  logic                    mux_v, mux_ready;
  link_word_t              mux_data;
  logic                    dmx_v, dmx_ready;
  link_word_t              dmx_data;

  logic     [NUM_CHAN-1:0] freed;
  logic                    credit_v;
  chan_id_t                credit_chan;
  credit_cnt_t             credit_cnt;

  for (genvar k = 0; k < NUM_CHAN; k++)
  begin : in_buf
    two_fifo #(.payload_t_type(payload_t)) fifo_inst
    (
      .core_clk_i, .arst_n_i,
      .v_i(ch_v_i[k]), .data_i(ch_data_i[k]), .ready_o(ch_ready_o[k]),
      .v_o(buf_v[k]), .data_o(buf_data[k]), .yumi_i(buf_yumi[k])
    );
  end

  tunnel_mux #(.NUM_CHAN(NUM_CHAN)) mux_inst
  (
    .core_clk_i, .arst_n_i,
    .in_v_i(buf_v), .in_data_i(buf_data), .in_yumi_o(buf_yumi),
    .freed_i(freed), .credit_v_i(credit_v), .credit_chan_i(credit_chan),
    .credit_cnt_i(credit_cnt),
    .link_v_o(mux_v), .link_data_o(mux_data), .link_ready_i(mux_ready)
  );

  hop_pipe #(.NUM_HOPS(`TUNNEL_NUM_HOPS)) hop_out
  (
    .core_clk_i, .arst_n_i,
    .v_i(mux_v), .data_i(mux_data), .ready_o(mux_ready),
    .v_o(link_v_o), .data_o(link_data_o), .ready_i(link_ready_i)
  );

  hop_pipe #(.NUM_HOPS(`TUNNEL_NUM_HOPS)) hop_in
  (
    .core_clk_i, .arst_n_i,
    .v_i(link_v_i), .data_i(link_data_i), .ready_o(link_ready_o),
    .v_o(dmx_v), .data_o(dmx_data), .ready_i(dmx_ready)
  );

  tunnel_demux #(.NUM_CHAN(NUM_CHAN)) demux_inst
  (
    .core_clk_i, .arst_n_i,
    .link_v_i(dmx_v), .link_data_i(dmx_data), .link_ready_o(dmx_ready),
    .ch_v_o, .ch_data_o, .ch_ready_i,
    .freed_o(freed), .credit_v_o(credit_v), .credit_chan_o(credit_chan),
    .credit_cnt_o(credit_cnt)
  );

endmodule

/* logic/tunnel_demux.sv */
`timescale 1ns/1ns

`include "tunnel_defs.svh"

module tunnel_demux
  import tunnel_pkg::*;
#(
  parameter int NUM_CHAN = `TUNNEL_NUM_CHAN
)
(
  input  logic                    core_clk_i,
  input  logic                    arst_n_i,

  input  logic                    link_v_i,
  input  link_word_t              link_data_i,
  output logic                    link_ready_o,

  output logic     [NUM_CHAN-1:0] ch_v_o,
  output payload_t [NUM_CHAN-1:0] ch_data_o,
  input  logic     [NUM_CHAN-1:0] ch_ready_i,

  output logic     [NUM_CHAN-1:0] freed_o,
  output logic                    credit_v_o,
  output chan_id_t                credit_chan_o,
  output credit_cnt_t             credit_cnt_o
);

  localparam int DEPTH = `TUNNEL_CREDITS;
  localparam int PTR_W = $clog2(DEPTH);

  logic        credit_v_r;
  chan_id_t    credit_chan_r;
  credit_cnt_t credit_cnt_r;
  logic        is_data;

  // Sender never overruns a buffer, so no back-pressure here
  assign link_ready_o = 1'b1;
  assign is_data      = link_v_i & (link_data_i.kind == KIND_DATA);

  for (genvar k = 0; k < NUM_CHAN; k++)
  begin : rx
    payload_t         mem_r [DEPTH];
    logic [PTR_W-1:0] wr_ptr_r;
    logic [PTR_W-1:0] rd_ptr_r;
    logic [PTR_W:0]   cnt_r;
    logic             wr;
    logic             rd;

    assign wr = is_data & (link_data_i.chan == chan_id_t'(k));
    assign rd = ch_v_o[k] & ch_ready_i[k];

    assign ch_v_o[k]    = (cnt_r != '0);
    assign ch_data_o[k] = mem_r[rd_ptr_r];
    assign freed_o[k]   = rd;           // One slot back to the far sender

    always_ff @(posedge core_clk_i or negedge arst_n_i)
    begin
      if (!arst_n_i)
      begin
        wr_ptr_r <= '0;
        rd_ptr_r <= '0;
        cnt_r    <= '0;
      end
      else
      begin
        if (wr)
          wr_ptr_r <= wr_ptr_r + 1'b1;
        if (rd)
          rd_ptr_r <= rd_ptr_r + 1'b1;
        cnt_r <= cnt_r + {{PTR_W{1'b0}}, wr} - {{PTR_W{1'b0}}, rd};
      end
    end

    always_ff @(posedge core_clk_i)
    begin
      if (wr)
        mem_r[wr_ptr_r] <= link_data_i.payload;
    end
  end

  // Credit words are reported for one cycle and never buffered
  always_ff @(posedge core_clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      credit_v_r <= 1'b0;
    else
      credit_v_r <= link_v_i & (link_data_i.kind == KIND_CREDIT);
  end

  always_ff @(posedge core_clk_i)
  begin
    if (link_v_i)
    begin
      credit_chan_r <= link_data_i.chan;
      credit_cnt_r  <= credit_of(link_data_i);
    end
  end

  assign credit_v_o    = credit_v_r;
  assign credit_chan_o = credit_chan_r;
  assign credit_cnt_o  = credit_cnt_r;

endmodule

/* logic/tunnel_mux.sv */
`timescale 1ns/1ns

`include "tunnel_defs.svh"

module tunnel_mux
  import tunnel_pkg::*;
#(
  parameter int NUM_CHAN = `TUNNEL_NUM_CHAN
)
(
  input  logic                    core_clk_i,
  input  logic                    arst_n_i,

  input  logic     [NUM_CHAN-1:0] in_v_i,
  input  payload_t [NUM_CHAN-1:0] in_data_i,
  output logic     [NUM_CHAN-1:0] in_yumi_o,

  input  logic     [NUM_CHAN-1:0] freed_i,
  input  logic                    credit_v_i,
  input  chan_id_t                credit_chan_i,
  input  credit_cnt_t             credit_cnt_i,

  output logic                    link_v_o,
  output link_word_t              link_data_o,
  input  logic                    link_ready_i
);

  credit_cnt_t         remote_cred [NUM_CHAN];
  credit_cnt_t         pend_cnt    [NUM_CHAN];
  logic [NUM_CHAN-1:0] has_cred;
  logic [NUM_CHAN-1:0] has_pend;

  logic       out_v_r;
  link_word_t out_data_r;
  chan_id_t   data_last_r;
  chan_id_t   cred_last_r;
  int         data_pick;
  int         cred_pick;
  logic       data_found, cred_found;
  chan_id_t   data_chan, cred_chan;
  logic       slot_free, send_data, send_cred;

  // First requester after the last winner, -1 when none
  function automatic int rr_pick(input logic [NUM_CHAN-1:0] req, input chan_id_t last);
    int idx;
    int pick;
    pick = -1;
    for (int k = NUM_CHAN; k >= 1; k--)
    begin
      idx = (int'(last) + k) % NUM_CHAN;
      if (req[idx])
        pick = idx;
    end
    return pick;
  endfunction

  assign cred_pick  = rr_pick(has_pend, cred_last_r);
  assign data_pick  = rr_pick(in_v_i & has_cred, data_last_r);
  assign cred_found = (cred_pick >= 0);
  assign data_found = (data_pick >= 0);
  assign cred_chan  = chan_id_t'(cred_pick);
  assign data_chan  = chan_id_t'(data_pick);

  assign slot_free = ~out_v_r | link_ready_i;
  assign send_cred = slot_free & cred_found;                // Credit returns go first
  assign send_data = slot_free & ~cred_found & data_found;

  for (genvar k = 0; k < NUM_CHAN; k++)
  begin : chan
    credit_cnt_t cred_r;   // Free slots at the far receiver
    credit_cnt_t pend_r;   // Drained here, not yet reported
    credit_cnt_t inc;
    logic        take;
    logic        ret;

    assign take = send_data & (data_chan == chan_id_t'(k));
    assign ret  = send_cred & (cred_chan == chan_id_t'(k));
    assign inc  = (credit_v_i && credit_chan_i == chan_id_t'(k)) ? credit_cnt_i : '0;

    always_ff @(posedge core_clk_i or negedge arst_n_i)
    begin
      if (!arst_n_i)
      begin
        cred_r <= credit_cnt_t'(`TUNNEL_CREDITS);
        pend_r <= '0;
      end
      else
      begin
        cred_r <= cred_r + inc - credit_cnt_t'(take);
        pend_r <= (ret ? credit_cnt_t'(0) : pend_r) + credit_cnt_t'(freed_i[k]);
      end
    end

    assign in_yumi_o[k]   = take;
    assign remote_cred[k] = cred_r;
    assign pend_cnt[k]    = pend_r;
    assign has_cred[k]    = (cred_r != '0);
    assign has_pend[k]    = (pend_r != '0);
  end

  always_ff @(posedge core_clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      out_v_r     <= 1'b0;
      data_last_r <= chan_id_t'(NUM_CHAN-1);
      cred_last_r <= chan_id_t'(NUM_CHAN-1);
    end
    else
    begin
      if (slot_free)
        out_v_r <= send_cred | send_data;   // Held while the hop stalls
      if (send_data)
        data_last_r <= data_chan;
      if (send_cred)
        cred_last_r <= cred_chan;
    end
  end

  always_ff @(posedge core_clk_i)
  begin
    if (send_cred)
      out_data_r <= make_credit_word(cred_chan, pend_cnt[cred_chan]);
    else if (send_data)
      out_data_r <= make_data_word(data_chan, in_data_i[data_chan]);
  end

  assign link_v_o    = out_v_r;
  assign link_data_o = out_data_r;

endmodule

/* logic/hop_pipe.sv */
`timescale 1ns/1ns

`include "tunnel_defs.svh"

module hop_pipe
  import tunnel_pkg::*;
#(
  parameter int NUM_HOPS = `TUNNEL_NUM_HOPS
)
(
  input  logic       core_clk_i,
  input  logic       arst_n_i,

  input  logic       v_i,
  input  link_word_t data_i,
  output logic       ready_o,

  output logic       v_o,
  output link_word_t data_o,
  input  logic       ready_i
);

  // Index 0 is the input side, NUM_HOPS the output side
  logic       [NUM_HOPS:0] v_chain;
  logic       [NUM_HOPS:0] ready_chain;
  link_word_t              data_chain [NUM_HOPS+1];

  assign v_chain[0]            = v_i;
  assign data_chain[0]         = data_i;
  assign ready_o               = ready_chain[0];

  assign v_o                   = v_chain[NUM_HOPS];
  assign data_o                = data_chain[NUM_HOPS];
  assign ready_chain[NUM_HOPS] = ready_i;

  for (genvar h = 0; h < NUM_HOPS; h++)
  begin : hop
    two_fifo #(.payload_t_type(link_word_t)) fifo_inst
    (
      .core_clk_i (core_clk_i),
      .arst_n_i   (arst_n_i),
      .v_i        (v_chain[h]),
      .data_i     (data_chain[h]),
      .ready_o    (ready_chain[h]),
      .v_o        (v_chain[h+1]),
      .data_o     (data_chain[h+1]),
      .yumi_i     (v_chain[h+1] & ready_chain[h+1])  // Ready downstream becomes yumi
    );
  end

endmodule

/* logic/two_fifo.sv */
`timescale 1ns/1ns

module two_fifo
#(
  parameter type payload_t_type = logic
)
(
  input  logic          core_clk_i,
  input  logic          arst_n_i,

  input  logic          v_i,
  input  payload_t_type data_i,
  output logic          ready_o,

  output logic          v_o,
  output payload_t_type data_o,
  input  logic          yumi_i
);

  payload_t_type mem_r [2];
  logic          wr_ptr_r;
  logic          rd_ptr_r;
  logic          full_r;
  logic          empty_r;
  logic          enq;
  logic          deq;

  assign enq = v_i & ready_o;
  assign deq = yumi_i;         // Consumer only yums a valid word

  assign ready_o = ~full_r;
  assign v_o     = ~empty_r;
  assign data_o  = mem_r[rd_ptr_r];

  always_ff @(posedge core_clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      wr_ptr_r <= 1'b0;
      rd_ptr_r <= 1'b0;
      full_r   <= 1'b0;
      empty_r  <= 1'b1;
    end
    else
    begin
      if (enq)
        wr_ptr_r <= ~wr_ptr_r;
      if (deq)
        rd_ptr_r <= ~rd_ptr_r;
      if (enq & ~deq)
      begin
        empty_r <= 1'b0;
        full_r  <= ~empty_r;   // Second entry taken
      end
      else if (deq & ~enq)
      begin
        full_r  <= 1'b0;
        empty_r <= ~full_r;
      end
    end
  end

  always_ff @(posedge core_clk_i)
  begin
    if (enq)
      mem_r[wr_ptr_r] <= data_i;
  end

endmodule

/* logic/tunnel_pkg.sv */
`include "tunnel_defs.svh"

package tunnel_pkg;

  typedef logic [1:0]                chan_id_t;
  typedef logic [`TUNNEL_DATA_W-1:0] payload_t;
  typedef logic [2:0]                credit_cnt_t;  // 0 to TUNNEL_CREDITS

  localparam logic KIND_DATA   = 1'b0;
  localparam logic KIND_CREDIT = 1'b1;

  // One word on the serial link
  typedef struct packed {
    logic     kind;
    chan_id_t chan;
    payload_t payload;  // Credit count sits in the low bits for credit words
  } link_word_t;

  function automatic link_word_t make_data_word(input chan_id_t chan, input payload_t data);
    return '{kind: KIND_DATA, chan: chan, payload: data};
  endfunction

  function automatic link_word_t make_credit_word(input chan_id_t chan, input credit_cnt_t cnt);
    return '{kind: KIND_CREDIT, chan: chan, payload: payload_t'(cnt)};
  endfunction

  function automatic credit_cnt_t credit_of(input link_word_t word);
    return word.payload[$bits(credit_cnt_t)-1:0];
  endfunction

endpackage

/* include/tunnel_defs.svh */
`ifndef TUNNEL_DEFS_SVH
`define TUNNEL_DEFS_SVH

// Local channels sharing one link
`define TUNNEL_NUM_CHAN 3

// Channel payload width
`define TUNNEL_DATA_W 16

// Receive buffer depth per channel on the far side, also the starting credit
`define TUNNEL_CREDITS 4

// Two-entry hop buffers in each link direction
`define TUNNEL_NUM_HOPS 2

`endif
